// ==== dbg_pkg.sv ====
////////////////////////////////////////
// Debug packet engine shared types
// Opcodes, parser states, byte beats and bus bundles
////////////////////////////////////////
package dbg_pkg;

  // Shared widths
  localparam int ADDR_W = 16;  // CPU and PPU address
  localparam int BYTE_W = 8;   // Packet and bus data
  localparam int CNT_W  = 16;  // Burst and echo length

  // Error code bit set by an unknown opcode
  localparam int ERR_UNKNOWN_OP = 1;

  ////////////////////////////////////////
  // Enums
  ////////////////////////////////////////

  // Packet opcodes, 0x05 and 0x06 decode as unknown
  typedef enum logic [7:0] {
    ECHO           = 8'h00,
    CPU_MEM_RD     = 8'h01,
    CPU_MEM_WR     = 8'h02,
    DBG_BRK        = 8'h03,
    DBG_RUN        = 8'h04,
    QUERY_DBG_BRK  = 8'h07,
    QUERY_ERR_CODE = 8'h08,
    PPU_MEM_RD     = 8'h09,
    PPU_MEM_WR     = 8'h0A
  } dbg_op_e;

  typedef enum logic [2:0] {
    S_DISABLED,    // CPU runs, only break and break query honored
    S_DECODE,      // Waiting for an opcode
    S_HEADER,      // Collecting address and count bytes
    S_ECHO_DATA,   // Returning echo payload
    S_WR_DATA,     // Forwarding write payload to the engine
    S_WAIT_BURST,  // Engine owns the reply path
    S_ERR_REPLY    // Sending the error code
  } parse_state_e;

  typedef enum logic {
    TGT_CPU = 1'b0,
    TGT_PPU = 1'b1
  } mem_target_e;

  ////////////////////////////////////////
  // Bundles
  ////////////////////////////////////////

  // One byte moving through the design
  typedef struct packed {
    logic              valid;
    logic [BYTE_W-1:0] data;
  } byte_beat_t;

  // Burst request from parser to engine
  typedef struct packed {
    logic              start;   // One-cycle pulse
    mem_target_e       target;
    logic              write;   // Low for a read burst
    logic [ADDR_W-1:0] addr;    // First address
    logic [CNT_W-1:0]  count;   // Number of bytes, never zero on start
  } mem_cmd_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [BYTE_W-1:0] dout;
    logic              r_nw;   // Low only on a write strobe
  } cpu_bus_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [BYTE_W-1:0] dout;
    logic              wr;     // Write enable
  } ppu_bus_t;

endpackage

// ==== dbg_rx_buffer.sv ====
////////////////////////////////////////
// Receive FIFO for host packet bytes
// Returns one rx credit per popped byte
////////////////////////////////////////
`timescale 1ns/10ps

module dbg_rx_buffer
  import dbg_pkg::*;
#(
  parameter int RX_DEPTH = 4
)
(
  input  logic       clk,
  input  logic       rst,
  input  byte_beat_t rx,
  input  logic       pop,
  output byte_beat_t head,
  output logic       rx_credit
);

  localparam int PTR_W = (RX_DEPTH > 1) ? $clog2(RX_DEPTH) : 1;
  localparam int OCC_W = $clog2(RX_DEPTH + 1);

  logic [BYTE_W-1:0] fifo_mem [RX_DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [OCC_W-1:0]  occ_q;     // Bytes currently held
  logic              push;
  logic              do_pop;

  // Circular increment, depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(RX_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign push   = rx.valid && (occ_q != OCC_W'(RX_DEPTH));  // Full FIFO drops, credits prevent it
  assign do_pop = pop && head.valid;

  // Head is read straight from storage
  assign head.valid = (occ_q != '0);
  assign head.data  = fifo_mem[rd_ptr_q];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      occ_q     <= '0;
      rx_credit <= 1'b0;
    end
    else
    begin
      if (push)
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (do_pop)
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      occ_q     <= occ_q + OCC_W'(push) - OCC_W'(do_pop);
      rx_credit <= do_pop;  // Credit goes back the cycle after the pop
    end
  end

  // Storage
  always_ff @(posedge clk)
  begin
    if (push)
      fifo_mem[wr_ptr_q] <= rx.data;
  end

endmodule

// ==== dbg_cmd_parser.sv ====
////////////////////////////////////////
// Debug packet parser
// Decodes opcodes and headers, owns break state and error code
////////////////////////////////////////
`timescale 1ns/10ps

module dbg_cmd_parser
  import dbg_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  byte_beat_t head,
  input  logic       brk,
  input  logic       busy,
  input  logic       tx_ready,
  output logic       pop,
  output mem_cmd_t   mem_cmd,
  output byte_beat_t wr_beat,
  output byte_beat_t parse_reply,
  output logic       cpu_ready
);

  parse_state_e      state_q, state_d;
  dbg_op_e           op_q, op_d;           // Opcode of the packet in progress
  dbg_op_e           op_in;
  logic [1:0]        hdr_idx_q, hdr_idx_d; // 0/1 address bytes, 2/3 count bytes
  logic [ADDR_W-1:0] addr_q, addr_d;
  logic [CNT_W-1:0]  cnt_q, cnt_d;         // Remaining payload bytes
  logic [BYTE_W-1:0] err_code_q, err_code_d;
  logic [CNT_W-1:0]  hdr_cnt;              // Full count as the high byte arrives

  assign op_in     = dbg_op_e'(head.data);
  assign hdr_cnt   = {head.data, cnt_q[BYTE_W-1:0]};
  assign cpu_ready = (state_q == S_DISABLED);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q    <= S_DISABLED;
      hdr_idx_q  <= '0;
      err_code_q <= '0;
    end
    else
    begin
      state_q    <= state_d;
      hdr_idx_q  <= hdr_idx_d;
      err_code_q <= err_code_d;
    end
    op_q   <= op_d;
    addr_q <= addr_d;
    cnt_q  <= cnt_d;
  end

  always_comb
  begin
    state_d    = state_q;
    op_d       = op_q;
    hdr_idx_d  = hdr_idx_q;
    addr_d     = addr_q;
    cnt_d      = cnt_q;
    err_code_d = err_code_q;

    pop         = 1'b0;
    wr_beat     = '{valid: 1'b0, data: head.data};  // Write data is the head byte itself
    parse_reply = '{valid: 1'b0, data: head.data};

    // Burst fields track the latched opcode, start pulses below
    mem_cmd.start  = 1'b0;
    mem_cmd.target = (op_q == PPU_MEM_RD || op_q == PPU_MEM_WR) ? TGT_PPU : TGT_CPU;
    mem_cmd.write  = (op_q == CPU_MEM_WR || op_q == PPU_MEM_WR);
    mem_cmd.addr   = addr_q;
    mem_cmd.count  = hdr_cnt;

    case (state_q)
      S_DISABLED:
      begin
        if (brk)
          state_d = S_DECODE;                        // CPU-initiated break wins
        else if (head.valid)
        begin
          if (op_in == QUERY_DBG_BRK)
          begin
            if (tx_ready)
            begin
              pop         = 1'b1;
              parse_reply = '{valid: 1'b1, data: 8'h00};  // Not in a break
            end
          end
          else
          begin
            pop = 1'b1;                              // Anything else is discarded
            if (op_in == DBG_BRK)
              state_d = S_DECODE;
          end
        end
      end

      S_DECODE:
      begin
        if (head.valid)
        begin
          pop = (op_in != QUERY_DBG_BRK) || tx_ready;  // Query waits for a credit
          if (pop)
          begin
            case (op_in)
              ECHO:
              begin
                op_d      = op_in;
                hdr_idx_d = 2'd2;                    // No address field
                state_d   = S_HEADER;
              end
              CPU_MEM_RD, CPU_MEM_WR, PPU_MEM_RD, PPU_MEM_WR:
              begin
                op_d      = op_in;
                hdr_idx_d = 2'd0;
                state_d   = S_HEADER;
              end
              DBG_BRK:        state_d = S_DECODE;    // Already in a break
              DBG_RUN:        state_d = S_DISABLED;
              QUERY_DBG_BRK:  parse_reply = '{valid: 1'b1, data: 8'h01};
              QUERY_ERR_CODE: state_d = S_ERR_REPLY;
              default:        err_code_d[ERR_UNKNOWN_OP] = 1'b1;  // Sticky
            endcase
          end
        end
      end

      S_HEADER:
      begin
        if (head.valid)
        begin
          pop       = 1'b1;
          hdr_idx_d = hdr_idx_q + 2'd1;
          case (hdr_idx_q)
            2'd0: addr_d[BYTE_W-1:0]      = head.data;
            2'd1: addr_d[ADDR_W-1:BYTE_W] = head.data;
            2'd2: cnt_d[BYTE_W-1:0]       = head.data;
            default:
            begin
              cnt_d = hdr_cnt;
              if (hdr_cnt == '0)
                state_d = S_DECODE;                  // Empty packet, nothing to do
              else if (op_q == ECHO)
                state_d = S_ECHO_DATA;
              else
              begin
                mem_cmd.start = 1'b1;
                state_d       = mem_cmd.write ? S_WR_DATA : S_WAIT_BURST;
              end
            end
          endcase
        end
      end

      S_ECHO_DATA:
      begin
        if (head.valid && tx_ready)
        begin
          pop         = 1'b1;
          parse_reply = '{valid: 1'b1, data: head.data};
          cnt_d       = cnt_q - 1'b1;
          if (cnt_q == CNT_W'(1))
            state_d = S_DECODE;
        end
      end

      S_WR_DATA:
      begin
        if (head.valid)
        begin
          pop           = 1'b1;
          wr_beat.valid = 1'b1;
          cnt_d         = cnt_q - 1'b1;
          if (cnt_q == CNT_W'(1))
            state_d = S_WAIT_BURST;                  // Last strobe still pending
        end
      end

      S_WAIT_BURST:
      begin
        if (!busy)
          state_d = S_DECODE;
      end

      S_ERR_REPLY:
      begin
        parse_reply = '{valid: 1'b1, data: err_code_q};  // Held until a credit shows up
        if (tx_ready)
          state_d = S_DECODE;
      end

      default: state_d = S_DISABLED;
    endcase
  end

endmodule

// ==== dbg_mem_engine.sv ====
////////////////////////////////////////
// Burst engine for the CPU and PPU buses
// Steps the address and paces read returns
////////////////////////////////////////
`timescale 1ns/10ps

module dbg_mem_engine
  import dbg_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  mem_cmd_t          mem_cmd,
  input  byte_beat_t        wr_beat,
  input  logic              tx_ready,
  input  logic [BYTE_W-1:0] cpu_din,
  input  logic [BYTE_W-1:0] ppu_din,
  output logic              busy,
  output byte_beat_t        mem_reply,
  output cpu_bus_t          cpu_bus,
  output ppu_bus_t          ppu_bus
);

  mem_target_e       target_q;
  logic              write_q;
  logic              settle_q;   // Address held one cycle before data is valid
  logic              strobe_q;   // Write strobe, one per forwarded byte
  logic [ADDR_W-1:0] addr_q;
  logic [CNT_W-1:0]  cnt_q;
  logic [BYTE_W-1:0] rd_data_q;
  logic [BYTE_W-1:0] wr_data_q;

  ////////////////////////////////////////
  // Burst control
  ////////////////////////////////////////
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      busy     <= 1'b0;
      write_q  <= 1'b0;
      target_q <= TGT_CPU;
      settle_q <= 1'b0;
      strobe_q <= 1'b0;
      addr_q   <= '0;
    end
    else
    begin
      strobe_q <= busy && write_q && wr_beat.valid;
      if (mem_cmd.start)
      begin
        busy     <= 1'b1;
        write_q  <= mem_cmd.write;
        target_q <= mem_cmd.target;
        addr_q   <= mem_cmd.addr;
        settle_q <= 1'b1;                        // First read address settles
      end
      else if (busy && !write_q)
      begin
        if (settle_q)
          settle_q <= 1'b0;
        else if (tx_ready)                       // Byte taken, next address
        begin
          addr_q   <= addr_q + 1'b1;
          settle_q <= 1'b1;
          if (cnt_q == CNT_W'(1))
            busy <= 1'b0;
        end
      end
      else if (busy && strobe_q)
      begin
        addr_q <= addr_q + 1'b1;                 // Step after each write strobe
        if (cnt_q == CNT_W'(1))
          busy <= 1'b0;
      end
    end
  end

  // Count, read sample and write data
  always_ff @(posedge clk)
  begin
    if (mem_cmd.start)
      cnt_q <= mem_cmd.count;
    else if (busy && ((!write_q && !settle_q && tx_ready) || (write_q && strobe_q)))
      cnt_q <= cnt_q - 1'b1;
    if (settle_q)
      rd_data_q <= (target_q == TGT_PPU) ? ppu_din : cpu_din;  // Sampled after settle
    if (wr_beat.valid)
      wr_data_q <= wr_beat.data;
  end

  ////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////
  assign mem_reply.valid = busy && !write_q && !settle_q;  // Held under back-pressure
  assign mem_reply.data  = rd_data_q;

  // Both buses always see the same address
  assign cpu_bus.addr = addr_q;
  assign cpu_bus.dout = wr_data_q;
  assign cpu_bus.r_nw = !(strobe_q && target_q == TGT_CPU);
  assign ppu_bus.addr = addr_q;
  assign ppu_bus.dout = wr_data_q;
  assign ppu_bus.wr   = strobe_q && (target_q == TGT_PPU);

endmodule

// ==== dbg_tx_merge.sv ====
////////////////////////////////////////
// Reply merger with tx credit counter
// Registers one reply byte per credit onto tx
////////////////////////////////////////
`timescale 1ns/10ps

module dbg_tx_merge
  import dbg_pkg::*;
#(
  parameter int TX_CREDITS = 2
)
(
  input  logic       clk,
  input  logic       rst,
  input  byte_beat_t parse_reply,
  input  byte_beat_t mem_reply,
  input  logic       tx_credit,
  output byte_beat_t tx,
  output logic       tx_ready
);

  localparam int CRED_W = $clog2(TX_CREDITS + 1) + 1;  // Headroom for early returns

  logic [CRED_W-1:0] credits_q;
  byte_beat_t        pick;
  logic              send;

  // Parser first; the two never overlap in practice
  assign pick     = parse_reply.valid ? parse_reply : mem_reply;
  assign tx_ready = (credits_q != '0);
  assign send     = tx_ready && pick.valid;  // Source sees the same condition

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      credits_q <= CRED_W'(TX_CREDITS);
      tx.valid  <= 1'b0;
    end
    else
    begin
      credits_q <= credits_q + CRED_W'(tx_credit) - CRED_W'(send);
      tx.valid  <= send;                     // Valid for exactly one cycle
    end
  end

  // Output data register
  always_ff @(posedge clk)
  begin
    if (send)
      tx.data <= pick.data;
  end

endmodule

// ==== dbg_top.sv ====
////////////////////////////////////////
// Debug packet engine top level
////////////////////////////////////////
`timescale 1ns/10ps

module dbg_top
  import dbg_pkg::*;
#(
  parameter int RX_DEPTH   = 4,
  parameter int TX_CREDITS = 2
)
(
  input  logic              clk,
  input  logic              rst,
  input  byte_beat_t        rx,
  input  logic              tx_credit,
  input  logic              brk,
  input  logic [BYTE_W-1:0] cpu_din,
  input  logic [BYTE_W-1:0] ppu_din,
  output logic              rx_credit,
  output byte_beat_t        tx,
  output cpu_bus_t          cpu_bus,
  output ppu_bus_t          ppu_bus,
  output logic              cpu_ready
);

  byte_beat_t head;         // FIFO head to parser
  byte_beat_t wr_beat;      // Write payload to engine
  byte_beat_t parse_reply;
  byte_beat_t mem_reply;
  mem_cmd_t   mem_cmd;
  logic       pop;
  logic       busy;
  logic       tx_ready;

  dbg_rx_buffer #(.RX_DEPTH(RX_DEPTH)) rx_buffer_i (
    .clk       (clk),
    .rst       (rst),
    .rx        (rx),
    .pop       (pop),
    .head      (head),
    .rx_credit (rx_credit)
  );

  dbg_cmd_parser cmd_parser_i (
    .clk         (clk),
    .rst         (rst),
    .head        (head),
    .brk         (brk),
    .busy        (busy),
    .tx_ready    (tx_ready),
    .pop         (pop),
    .mem_cmd     (mem_cmd),
    .wr_beat     (wr_beat),
    .parse_reply (parse_reply),
    .cpu_ready   (cpu_ready)
  );

  dbg_mem_engine mem_engine_i (
    .clk       (clk),
    .rst       (rst),
    .mem_cmd   (mem_cmd),
    .wr_beat   (wr_beat),
    .tx_ready  (tx_ready),
    .cpu_din   (cpu_din),
    .ppu_din   (ppu_din),
    .busy      (busy),
    .mem_reply (mem_reply),
    .cpu_bus   (cpu_bus),
    .ppu_bus   (ppu_bus)
  );

  dbg_tx_merge #(.TX_CREDITS(TX_CREDITS)) tx_merge_i (
    .clk         (clk),
    .rst         (rst),
    .parse_reply (parse_reply),
    .mem_reply   (mem_reply),
    .tx_credit   (tx_credit),
    .tx          (tx),
    .tx_ready    (tx_ready)
  );

endmodule

// ==== tb_clk_gen.sv ====
////////////////////////////////////////
// Testbench clock source, 4 ns period
////////////////////////////////////////
`timescale 1ns/10ps

module tb_clk_gen #(
  parameter real HALF_NS = 2.0  // Half of the clock period
)
(
  output logic clk
);

  initial clk = 1'b0;
  always #(HALF_NS) clk = ~clk;

endmodule

// ==== tb_dbg_top.sv ====
////////////////////////////////////////
// Testbench for the debug packet engine
// Host, link and memory models checked against a reference model
////////////////////////////////////////
`timescale 1ns/10ps

module tb_dbg_top
  import dbg_pkg::*;
();

  localparam int RX_DEPTH   = 4;
  localparam int TX_CREDITS = 2;

  logic              clk;
  logic              rst       = 1'b1;
  byte_beat_t        rx        = '0;
  logic              tx_credit = 1'b0;
  logic              brk       = 1'b0;
  logic [BYTE_W-1:0] cpu_din;
  logic [BYTE_W-1:0] ppu_din;
  logic              rx_credit;
  byte_beat_t        tx;
  cpu_bus_t          cpu_bus;
  ppu_bus_t          ppu_bus;
  logic              cpu_ready;

  logic [7:0]  cpu_mem [256];  // Bus-side memories
  logic [7:0]  ppu_mem [256];
  logic [7:0]  cpu_ref [256];  // Mirrors kept by the reference model
  logic [7:0]  ppu_ref [256];
  logic [7:0]  host_q[$];      // Packet bytes waiting for an rx credit
  logic [7:0]  exp_q[$];       // Expected reply bytes, in order
  logic [23:0] cpu_wr_q[$];    // Expected CPU strobes as address and data
  logic [23:0] ppu_wr_q[$];

  int         seed          = 65484;
  string      test_name     = "reset";
  int         host_credits  = RX_DEPTH;
  int         bytes_sent    = 0;
  int         credit_pulses = 0;
  int         pkt_bytes     = 0;  // Sets the timeout limit
  int         owed_credits  = 0;
  int         credit_delay  = 0;
  int         withhold      = 0;  // Cycles with tx credits held back
  int         cycles        = 0;
  int         value_errors  = 0;
  int         other_errors  = 0;
  logic       ref_brk       = 1'b0;
  logic [7:0] ref_err       = 8'h00;

  tb_clk_gen clk_gen_i (.clk(clk));

  dbg_top #(.RX_DEPTH(RX_DEPTH), .TX_CREDITS(TX_CREDITS)) dbg_top_i (
    .clk       (clk),
    .rst       (rst),
    .rx        (rx),
    .tx_credit (tx_credit),
    .brk       (brk),
    .cpu_din   (cpu_din),
    .ppu_din   (ppu_din),
    .rx_credit (rx_credit),
    .tx        (tx),
    .cpu_bus   (cpu_bus),
    .ppu_bus   (ppu_bus),
    .cpu_ready (cpu_ready)
  );

  ////////////////////////////////////////
  // Memory models
  ////////////////////////////////////////
  assign cpu_din = $isunknown(cpu_bus.addr) ? 8'h00 : cpu_mem[cpu_bus.addr[7:0]];
  assign ppu_din = $isunknown(ppu_bus.addr) ? 8'h00 : ppu_mem[ppu_bus.addr[7:0]];

  always @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < 256; i++)
      begin
        cpu_mem[i] <= 8'(i * 29 + 8'h3C);  // Fill follows the whole index
        ppu_mem[i] <= 8'((i * 53) ^ 8'h96);
      end
    end
    else
    begin
      if (!cpu_bus.r_nw)
        cpu_mem[cpu_bus.addr[7:0]] <= cpu_bus.dout;
      if (ppu_bus.wr)
        ppu_mem[ppu_bus.addr[7:0]] <= ppu_bus.dout;
    end
  end

  ////////////////////////////////////////
  // Host and link models
  ////////////////////////////////////////
  always @(negedge clk)
  begin
    if (rx_credit === 1'b1)
    begin
      host_credits  = host_credits + 1;
      credit_pulses = credit_pulses + 1;
    end
    if (!rst && host_q.size() > 0 && host_credits > 0)
    begin
      rx <= {1'b1, host_q.pop_front()};  // One byte per credit
      host_credits = host_credits - 1;
      bytes_sent   = bytes_sent + 1;
    end
    else
      rx <= '0;
  end

  // Reply sink, returns one tx credit per byte after a random delay
  always @(negedge clk)
  begin
    tx_credit <= 1'b0;
    if (tx.valid === 1'b1)
    begin
      check_reply(tx.data);
      owed_credits = owed_credits + 1;
    end
    if (withhold > 0)
      withhold = withhold - 1;
    else if (credit_delay > 0)
      credit_delay = credit_delay - 1;
    else if (owed_credits > 0)
    begin
      tx_credit <= 1'b1;
      owed_credits = owed_credits - 1;
      credit_delay = rand_range(0, 3);
    end
  end

  // Write strobes against the expected strobe lists
  always @(negedge clk)
  begin
    if (!rst && cpu_bus.r_nw === 1'b0)
    begin
      if (cpu_wr_q.size() == 0)
        report_stray("CPU");
      else
        check_strobe("CPU", cpu_wr_q.pop_front(), {cpu_bus.addr, cpu_bus.dout});
    end
    if (!rst && ppu_bus.wr === 1'b1)
    begin
      if (ppu_wr_q.size() == 0)
        report_stray("PPU");
      else
        check_strobe("PPU", ppu_wr_q.pop_front(), {ppu_bus.addr, ppu_bus.dout});
    end
  end

  // Run limit grows with the packet bytes queued so far
  always @(negedge clk)
  begin
    cycles = cycles + 1;
    if (cycles > 40 * pkt_bytes + 2000)
    begin
      $display("Timeout after %0d cycles in test %s, the DUT stopped responding",
               cycles, test_name);
      $display(">>> FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Checks and reference model
  ////////////////////////////////////////
  function automatic int rand_range(input int lo, input int hi);
    return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
  endfunction

  task automatic check_reply(input logic [7:0] actual);
    logic [7:0] expected;
    if (exp_q.size() == 0)
    begin
      other_errors++;
      $display("Unexpected tx byte 0x%02h in test %s, no reply was due", actual, test_name);
    end
    else
    begin
      expected = exp_q.pop_front();
      if (actual !== expected)
      begin
        value_errors++;
        $display("CHECK FAILED %s: tx expected 0x%02h, actual 0x%02h",
                 test_name, expected, actual);
      end
    end
  endtask

  task automatic check_strobe(input string bus, input logic [23:0] expected,
                              input logic [23:0] actual);
    if (actual !== expected)
    begin
      value_errors++;
      $display("CHECK FAILED %s: %s strobe expected 0x%06h, actual 0x%06h",
               test_name, bus, expected, actual);
    end
  endtask

  task automatic report_stray(input string bus);
    other_errors++;
    $display("A %s write strobe came in test %s when none was due", bus, test_name);
  endtask

  task automatic check_ready(input logic expected);
    @(negedge clk);
    if (cpu_ready !== expected)
    begin
      value_errors++;
      $display("CHECK FAILED %s: cpu_ready expected %0b, actual %0b",
               test_name, expected, cpu_ready);
    end
    @(posedge clk);
  endtask

  task automatic send_byte(input logic [7:0] b);
    host_q.push_back(b);
    pkt_bytes++;
  endtask

  task automatic send_header(input logic [7:0] op, input logic [15:0] addr,
                             input logic [15:0] cnt);
    send_byte(op);
    if (op != ECHO)
    begin
      send_byte(addr[7:0]);  // Low byte first
      send_byte(addr[15:8]);
    end
    send_byte(cnt[7:0]);
    send_byte(cnt[15:8]);
  endtask

  task automatic send_brk_query();
    send_byte(QUERY_DBG_BRK);
    exp_q.push_back(ref_brk ? 8'h01 : 8'h00);
  endtask

  task automatic send_err_query();
    send_byte(QUERY_ERR_CODE);
    exp_q.push_back(ref_err);
  endtask

  task automatic send_echo(input int len);
    logic [7:0] d;
    send_header(ECHO, 16'h0000, 16'(len));
    for (int i = 0; i < len; i++)
    begin
      d = 8'(rand_range(0, 255));
      send_byte(d);
      exp_q.push_back(d);  // Same bytes, same order
    end
  endtask

  task automatic send_mem_wr(input logic ppu, input logic [15:0] addr, input int len);
    logic [7:0]  d;
    logic [15:0] a;
    send_header(ppu ? PPU_MEM_WR : CPU_MEM_WR, addr, 16'(len));
    for (int i = 0; i < len; i++)
    begin
      d = 8'(rand_range(0, 255));
      a = addr + 16'(i);
      send_byte(d);
      if (ppu)
      begin
        ppu_ref[a[7:0]] = d;
        ppu_wr_q.push_back({a, d});
      end
      else
      begin
        cpu_ref[a[7:0]] = d;
        cpu_wr_q.push_back({a, d});
      end
    end
  endtask

  task automatic send_mem_rd(input logic ppu, input logic [15:0] addr, input int len);
    logic [15:0] a;
    send_header(ppu ? PPU_MEM_RD : CPU_MEM_RD, addr, 16'(len));
    for (int i = 0; i < len; i++)
    begin
      a = addr + 16'(i);
      exp_q.push_back(ppu ? ppu_ref[a[7:0]] : cpu_ref[a[7:0]]);
    end
  endtask

  task automatic pulse_brk();
    @(negedge clk);
    brk <= 1'b1;
    @(negedge clk);
    brk <= 1'b0;
    ref_brk = 1'b1;
    @(posedge clk);
  endtask

  // Everything sent, answered, strobed and credited back
  task automatic wait_idle();
    while (host_q.size() != 0 || exp_q.size() != 0 || cpu_wr_q.size() != 0 ||
           ppu_wr_q.size() != 0 || host_credits < RX_DEPTH)
      @(posedge clk);
    @(posedge clk);
  endtask

  task automatic compare_mems();
    for (int i = 0; i < 256; i++)
    begin
      if (cpu_mem[i] !== cpu_ref[i] || ppu_mem[i] !== ppu_ref[i])
      begin
        value_errors++;
        $display("CHECK FAILED %s: mem[0x%02h] expected 0x%02h/0x%02h, actual 0x%02h/0x%02h",
                 test_name, i, cpu_ref[i], ppu_ref[i], cpu_mem[i], ppu_mem[i]);
      end
    end
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////
  initial
  begin
    for (int i = 0; i < 256; i++)
    begin
      cpu_ref[i] = 8'(i * 29 + 8'h3C);
      ppu_ref[i] = 8'((i * 53) ^ 8'h96);
    end
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(posedge clk);
    check_ready(1'b1);

    test_name = "brk_query";
    send_brk_query();  // Disabled, replies 0x00
    wait_idle();
    check_ready(1'b1);
    send_byte(DBG_BRK);
    ref_brk = 1'b1;
    send_brk_query();
    test_name = "err_after_reset";
    send_err_query();
    wait_idle();
    check_ready(1'b0);

    test_name = "dbg_run";
    send_byte(DBG_RUN);
    ref_brk = 1'b0;
    send_brk_query();
    wait_idle();
    check_ready(1'b1);

    test_name = "brk_pulse";
    pulse_brk();
    send_brk_query();
    wait_idle();
    check_ready(1'b0);

    test_name = "echo";
    for (int n = 0; n < 4; n++)
      send_echo(rand_range(1, 20));
    send_echo(0);  // Empty echo, no reply
    send_brk_query();
    wait_idle();

    test_name = "cpu_mem";
    begin
      logic [15:0] addr;
      int          len;
      addr = 16'(rand_range(0, 65535));
      len  = rand_range(1, 20);
      send_mem_wr(1'b0, addr, len);
      send_mem_rd(1'b0, addr, len);
      wait_idle();
      test_name = "ppu_mem";
      addr = 16'(rand_range(0, 65535));
      len  = rand_range(1, 20);
      send_mem_wr(1'b1, addr, len);
      send_mem_rd(1'b1, addr, len);
      wait_idle();
      compare_mems();  // CPU side must be untouched
    end

    test_name = "err_code";
    send_byte(rand_range(0, 1) ? 8'h05 : 8'(rand_range(8'h0B, 8'hFF)));
    ref_err[1] = 1'b1;  // Unknown opcode flag
    send_err_query();
    send_echo(rand_range(1, 4));
    send_err_query();  // Sticky
    wait_idle();

    test_name = "backpressure";
    withhold = rand_range(20, 60);
    send_mem_rd(1'b0, 16'(rand_range(0, 65535)), rand_range(12, 20));
    wait_idle();
    withhold = rand_range(20, 60);
    send_mem_rd(1'b1, 16'(rand_range(0, 65535)), rand_range(12, 20));
    wait_idle();

    test_name = "final";
    repeat (20) @(posedge clk);  // Quiet window for late bytes, strobes and credits
    compare_mems();
    if (credit_pulses != bytes_sent)
    begin
      value_errors++;
      $display("CHECK FAILED %s: rx credits expected %0d, actual %0d",
               test_name, bytes_sent, credit_pulses);
    end

    $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

// ==== list.f ====
dbg_pkg.sv
dbg_rx_buffer.sv
dbg_cmd_parser.sv
dbg_mem_engine.sv
dbg_tx_merge.sv
dbg_top.sv
tb_clk_gen.sv
tb_dbg_top.sv

// ==== Bender.yml ====
package:
  name: dbg_engine

sources:
  # RTL in compile order
  - dbg_pkg.sv
  - dbg_rx_buffer.sv
  - dbg_cmd_parser.sv
  - dbg_mem_engine.sv
  - dbg_tx_merge.sv
  - dbg_top.sv
  # Testbench
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_dbg_top.sv
